// ==== src/mips16Pkg.sv ====
package mips16Pkg;

	//////////////////////////////////////////////////
	// Instruction formats, MSB first
	//////////////////////////////////////////////////

	typedef struct packed {
		logic [4:0] opcode;
		logic [2:0] rx;
		logic [2:0] ry;
		logic [4:0] imm;   // ADDIU3 uses low 4 bits
	} rriFmt;

	typedef struct packed {
		logic [4:0] opcode;
		logic [2:0] rx;    // Sub-code for the 01100 group
		logic [7:0] imm;
	} ri8Fmt;

	typedef struct packed {
		logic [4:0]  opcode;
		logic [10:0] imm;  // B offset in words
	} i11Fmt;

	typedef struct packed {
		logic [4:0] opcode;
		logic [2:0] rx;
		logic [2:0] ry;
		logic [2:0] rz;    // Shift count for SLL/SRA
		logic [1:0] funct;
	} rrrFmt;

	typedef struct packed {
		logic [4:0] opcode;
		logic [2:0] rx;
		logic [2:0] ry;    // Sub-code for JR/MFPC
		logic [4:0] funct;
	} aluFmt;

	// Same 16 bits, one view per format
	typedef union packed {
		logic [15:0] raw;
		rriFmt       rri;
		ri8Fmt       ri8;
		i11Fmt       i11;
		rrrFmt       rrr;
		aluFmt       alu;
	} instrWord;

	//////////////////////////////////////////////////
	// Decode results
	//////////////////////////////////////////////////

	typedef enum logic [4:0] {
		addiu3, addiu, addsp, addu, subu, andOp, orOp, cmp,
		neg, notOp, slt, sltui, sll, sra, li, lw,
		lwSp, sw, swSp, move, mfih, mtih, mfpc, mtsp,
		jr, b, beqz, bnez, bteqz, nop, illegal
	} opKind;

	typedef enum logic [2:0] {
		none,        // Not a control transfer
		alwaysTaken, // B
		ifZero,      // BEQZ
		ifNonZero,   // BNEZ
		ifTZero,     // BTEQZ
		jumpReg      // JR
	} branchKind;

	// Canonical nop, also filler past the end of the program
	localparam logic [15:0] NopWord = 16'h0800;

endpackage

// ==== src/instrRom.sv ====
`timescale 1ns/100ps

module instrRom #(
	parameter int MemWords = 40
) (
	input  logic        clk,
	input  logic [15:0] pc,
	output logic [15:0] instruction
);
	import mips16Pkg::*;

	localparam int AddrBits = (MemWords > 1) ? $clog2(MemWords) : 1;

	logic [15:0] memPool [0:MemWords-1]; // Program image
	logic [13:0] wordIdx;                // Byte PC to word index
	logic        inRange;

	// Image loaded once, never written
	initial begin
		$readmemh("program.hex", memPool);
	end

	assign wordIdx = pc[15:2];
	assign inRange = (32'(wordIdx) < MemWords);

	//////////////////////////////////////////////////
	// Asynchronous read, clk only paces the PC outside
	//////////////////////////////////////////////////
	always_comb begin
		if (inRange) begin
			instruction = memPool[wordIdx[AddrBits-1:0]];
		end else begin
			instruction = NopWord; // Fell off the end
		end
	end

endmodule

// ==== src/instrDecoder.sv ====
`timescale 1ns/100ps

module instrDecoder (
	input  logic [15:0]          instruction,
	output mips16Pkg::opKind     op,
	output logic [2:0]           rx,
	output logic [2:0]           ry,
	output logic [2:0]           rz,
	output logic [15:0]          imm,
	output mips16Pkg::branchKind branch,
	output logic [15:0]          branchOffset
);
	import mips16Pkg::*;

	instrWord   iw;
	logic [2:0] shamt;

	assign iw.raw = instruction;
	assign shamt  = iw.rrr.rz; // SLL/SRA count

	//////////////////////////////////////////////////
	// Opcode decode
	//////////////////////////////////////////////////
	always_comb begin
		op     = illegal;
		rx     = '0;
		ry     = '0;
		rz     = '0;
		imm    = '0;
		branch = none;
		case (iw.i11.opcode)
			5'b00001: if (iw.raw == NopWord) op = nop;
			5'b00010: begin
				op     = b;
				imm    = 16'($signed(iw.i11.imm));
				branch = alwaysTaken;
			end
			5'b00100, 5'b00101: begin // BEQZ / BNEZ
				op     = iw.i11.opcode[0] ? bnez : beqz;
				rx     = iw.ri8.rx;
				imm    = 16'($signed(iw.ri8.imm));
				branch = iw.i11.opcode[0] ? ifNonZero : ifZero;
			end
			5'b00110: begin
				rx  = iw.rrr.rx;
				ry  = iw.rrr.ry;
				imm = (shamt == 3'd0) ? 16'd8 : 16'(shamt); // 0 shifts by 8
				if (iw.rrr.funct == 2'b00) op = sll;
				else if (iw.rrr.funct == 2'b11) op = sra;
			end
			5'b01000: begin
				rx  = iw.rri.rx;
				ry  = iw.rri.ry;
				imm = 16'($signed(iw.rri.imm[3:0])); // 4-bit signed
				if (!iw.rri.imm[4]) op = addiu3;
			end
			5'b01001, 5'b10010, 5'b11010: begin // ADDIU, LW_SP, SW_SP
				rx  = iw.ri8.rx;
				imm = 16'($signed(iw.ri8.imm));
				case (iw.i11.opcode)
					5'b01001: op = addiu;
					5'b10010: op = lwSp;
					default:  op = swSp;
				endcase
			end
			5'b01011, 5'b01101: begin // SLTUI / LI, unsigned imm
				rx  = iw.ri8.rx;
				imm = 16'(iw.ri8.imm);
				op  = iw.i11.opcode[1] ? sltui : li;
			end
			5'b01100: begin
				case (iw.ri8.rx) // Sub-code group
					3'b000: begin
						op     = bteqz;
						imm    = 16'($signed(iw.ri8.imm));
						branch = ifTZero;
					end
					3'b011: begin
						op  = addsp;
						imm = 16'($signed(iw.ri8.imm));
					end
					3'b100: begin
						rx = iw.rri.ry; // MTSP source in bits 7:5
						if (iw.rri.imm == 5'd0) op = mtsp;
					end
					default: op = illegal;
				endcase
			end
			5'b01111: begin
				rx = iw.rri.rx;
				ry = iw.rri.ry;
				if (iw.rri.imm == 5'd0) op = move;
			end
			5'b10011, 5'b11011: begin // LW / SW
				rx  = iw.rri.rx;
				ry  = iw.rri.ry;
				imm = 16'($signed(iw.rri.imm));
				op  = iw.i11.opcode[3] ? sw : lw;
			end
			5'b11100: begin
				rx = iw.rrr.rx;
				ry = iw.rrr.ry;
				rz = iw.rrr.rz;
				if (iw.rrr.funct == 2'b01) op = addu;
				else if (iw.rrr.funct == 2'b11) op = subu;
			end
			5'b11101: begin
				rx = iw.alu.rx;
				ry = iw.alu.ry;
				case (iw.alu.funct)
					5'b00010: op = slt;
					5'b01010: op = cmp;
					5'b01011: op = neg;
					5'b01100: op = andOp;
					5'b01101: op = orOp;
					5'b01111: op = notOp;
					5'b00000: begin
						ry = '0; // ry holds JR/MFPC sub-code
						if (iw.alu.ry == 3'b000) begin
							op     = jr;
							branch = jumpReg;
						end else if (iw.alu.ry == 3'b010) begin
							op = mfpc;
						end
					end
					default: op = illegal;
				endcase
			end
			5'b11110: begin
				rx  = iw.ri8.rx;
				imm = 16'(iw.ri8.imm);
				if (iw.ri8.imm == 8'h00) op = mfih;
				else if (iw.ri8.imm == 8'h01) op = mtih;
			end
			default: op = illegal;
		endcase

		// Unknown codes report nothing
		if (op == illegal) begin
			rx     = '0;
			ry     = '0;
			rz     = '0;
			imm    = '0;
			branch = none;
		end
	end

	// Word offset for relative branches only
	assign branchOffset = (branch == none || branch == jumpReg) ? 16'd0 : imm;

endmodule

// ==== src/pcUnit.sv ====
`timescale 1ns/100ps

module pcUnit (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 stall,
	input  mips16Pkg::branchKind branch,
	input  logic [15:0]          branchOffset,
	input  logic [15:0]          rxValue,
	input  logic                 tFlag,
	output logic [15:0]          pc
);
	import mips16Pkg::*;

	logic [15:0] seqPc;  // Fall-through
	logic [15:0] relPc;  // Relative target
	logic [15:0] nextPc;
	logic        taken;

	assign seqPc = pc + 16'd4;
	assign relPc = seqPc + {branchOffset[13:0], 2'b00}; // Words to bytes

	//////////////////////////////////////////////////
	// Branch condition
	//////////////////////////////////////////////////
	always_comb begin
		case (branch)
			alwaysTaken: taken = 1'b1;
			ifZero:      taken = (rxValue == 16'd0);
			ifNonZero:   taken = (rxValue != 16'd0);
			ifTZero:     taken = ~tFlag;
			default:     taken = 1'b0; // none, jumpReg
		endcase
	end

	always_comb begin
		if (branch == jumpReg) begin
			nextPc = rxValue; // Absolute register target
		end else if (taken) begin
			nextPc = relPc;
		end else begin
			nextPc = seqPc;
		end
	end

	// PC register, frozen by stall
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= 16'd0;
		end else if (!stall) begin
			pc <= nextPc;
		end
	end

endmodule

// ==== src/mips16Fetch.sv ====
`timescale 1ns/100ps

module mips16Fetch #(
	parameter int MemWords = 40 // Program store depth in words
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 stall,
	input  logic [15:0]          rxValue, // Register rx for BEQZ/BNEZ/JR
	input  logic                 tFlag,
	output logic [15:0]          pc,
	output logic [15:0]          instruction,
	output mips16Pkg::opKind     op,
	output logic [2:0]           rx,
	output logic [2:0]           ry,
	output logic [2:0]           rz,
	output logic [15:0]          imm,
	output mips16Pkg::branchKind branch
);

	logic [15:0] branchOffset; // Decoder back to PC unit

	//////////////////////////////////////////////////
	// Fetch loop
	//////////////////////////////////////////////////
	pcUnit i_pcUnit (
		.clk          (clk),
		.rst          (rst),
		.stall        (stall),
		.branch       (branch),
		.branchOffset (branchOffset),
		.rxValue      (rxValue),
		.tFlag        (tFlag),
		.pc           (pc)
	);

	instrRom #(
		.MemWords (MemWords)
	) i_instrRom (
		.clk         (clk),
		.pc          (pc),
		.instruction (instruction)
	);

	instrDecoder i_instrDecoder (
		.instruction  (instruction),
		.op           (op),
		.rx           (rx),
		.ry           (ry),
		.rz           (rz),
		.imm          (imm),
		.branch       (branch),
		.branchOffset (branchOffset)
	);

endmodule

// ==== tb/mips16FetchTb.sv ====
`timescale 1ns/100ps

module mips16FetchTb;
	import mips16Pkg::*;

	localparam int MemWords   = 40;
	localparam int SeqCycles  = 20;
	localparam int RandCycles = 400;
	localparam int TestCycles = 3 + 1 + 4 + SeqCycles + RandCycles + 1;

	// Expected decode of one word
	typedef struct packed {
		opKind       op;
		logic [2:0]  rx;
		logic [2:0]  ry;
		logic [2:0]  rz;
		logic [15:0] imm;
		branchKind   br;
	} decodeRes;

	logic        clk;
	logic        rst;
	logic        stall;
	logic [15:0] rxValue;
	logic        tFlag;
	logic [15:0] pc;
	logic [15:0] instruction;
	opKind       op;
	logic [2:0]  rx;
	logic [2:0]  ry;
	logic [2:0]  rz;
	logic [15:0] imm;
	branchKind   branch;

	logic [15:0] progMem [0:MemWords-1]; // Own copy of the image
	logic [15:0] expPc;                  // Model PC
	logic        synced;                 // Model valid after first reset edge
	int          checkCount;
	int          errorCount;

	mips16Fetch #(
		.MemWords (MemWords)
	) i_mips16Fetch (
		.clk         (clk),
		.rst         (rst),
		.stall       (stall),
		.rxValue     (rxValue),
		.tFlag       (tFlag),
		.pc          (pc),
		.instruction (instruction),
		.op          (op),
		.rx          (rx),
		.ry          (ry),
		.rz          (rz),
		.imm         (imm),
		.branch      (branch)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk; // 100 ns period

	//////////////////////////////////////////////////
	// Reference decode, straight from the encodings
	//////////////////////////////////////////////////
	function automatic decodeRes refDecode(input logic [15:0] w);
		decodeRes d;
		d    = '0;
		d.op = illegal; // Anything unmatched
		casez (w)
			16'b00001_000_0000_0000:  d.op = nop;
			16'b00010_???_????????:   d.op = b;
			16'b00100_???_????????:   d.op = beqz;
			16'b00101_???_????????:   d.op = bnez;
			16'b00110_???_???_???_00: d.op = sll;
			16'b00110_???_???_???_11: d.op = sra;
			16'b01000_???_???_0????:  d.op = addiu3;
			16'b01001_???_????????:   d.op = addiu;
			16'b01011_???_????????:   d.op = sltui;
			16'b01100_000_????????:   d.op = bteqz;
			16'b01100_011_????????:   d.op = addsp;
			16'b01100_100_???_00000:  d.op = mtsp;
			16'b01101_???_????????:   d.op = li;
			16'b01111_???_???_00000:  d.op = move;
			16'b10010_???_????????:   d.op = lwSp;
			16'b10011_???_???_?????:  d.op = lw;
			16'b11010_???_????????:   d.op = swSp;
			16'b11011_???_???_?????:  d.op = sw;
			16'b11100_???_???_???_01: d.op = addu;
			16'b11100_???_???_???_11: d.op = subu;
			16'b11101_???_???_00010:  d.op = slt;
			16'b11101_???_???_01010:  d.op = cmp;
			16'b11101_???_???_01011:  d.op = neg;
			16'b11101_???_???_01100:  d.op = andOp;
			16'b11101_???_???_01101:  d.op = orOp;
			16'b11101_???_???_01111:  d.op = notOp;
			16'b11101_???_000_00000:  d.op = jr;
			16'b11101_???_010_00000:  d.op = mfpc;
			16'b11110_???_00000000:   d.op = mfih;
			16'b11110_???_00000001:   d.op = mtih;
			default: ;
		endcase
		// Register fields by format
		if (d.op inside {beqz, bnez, sll, sra, addiu3, addiu, sltui, li, move, lwSp, swSp, lw,
				sw, addu, subu, slt, cmp, neg, andOp, orOp, notOp, jr, mfpc, mfih, mtih}) begin
			d.rx = w[10:8];
		end
		if (d.op == mtsp) d.rx = w[7:5]; // Source sits one field lower
		if (d.op inside {sll, sra, addiu3, move, lw, sw, addu, subu, slt, cmp, neg, andOp,
				orOp, notOp}) begin
			d.ry = w[7:5];
		end
		if (d.op inside {addu, subu}) d.rz = w[4:2];
		case (d.op)
			b:                                          d.imm = {{5{w[10]}}, w[10:0]};
			beqz, bnez, bteqz, addiu, addsp, lwSp, swSp: d.imm = {{8{w[7]}}, w[7:0]};
			li, sltui, mfih, mtih:                      d.imm = {8'd0, w[7:0]}; // Zero-extend
			addiu3:                                     d.imm = {{12{w[3]}}, w[3:0]};
			lw, sw:                                     d.imm = {{11{w[4]}}, w[4:0]};
			sll, sra: d.imm = (w[4:2] == 3'd0) ? 16'd8 : {13'd0, w[4:2]}; // Count 0 is 8
			default:                                    d.imm = 16'd0;
		endcase
		case (d.op)
			b:       d.br = alwaysTaken;
			beqz:    d.br = ifZero;
			bnez:    d.br = ifNonZero;
			bteqz:   d.br = ifTZero;
			jr:      d.br = jumpReg;
			default: d.br = none;
		endcase
		return d;
	endfunction

	task automatic checkValue(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	//////////////////////////////////////////////////
	// Model and compare, sampled at the rising edge
	//////////////////////////////////////////////////
	always @(posedge clk) begin
		logic [15:0] word;
		decodeRes    want;
		int          idx;
		logic        take;
		idx  = int'(expPc[15:2]);
		word = (idx < MemWords) ? progMem[idx] : NopWord; // Past the end reads nop
		want = refDecode(word);
		if (synced) begin
			checkValue("pc", pc, expPc);
			checkValue("instruction", instruction, word);
			checkValue("op", 16'(op), 16'(want.op));
			checkValue("rx", 16'(rx), 16'(want.rx));
			checkValue("ry", 16'(ry), 16'(want.ry));
			checkValue("rz", 16'(rz), 16'(want.rz));
			checkValue("imm", imm, want.imm);
			checkValue("branch", 16'(branch), 16'(want.br));
		end
		take = (want.br == alwaysTaken) || (want.br == ifZero && rxValue == 16'd0)
			|| (want.br == ifNonZero && rxValue != 16'd0) || (want.br == ifTZero && !tFlag);
		if (rst) begin
			expPc  = 16'd0;
			synced = 1'b1;
		end else if (!stall) begin
			if (want.br == jumpReg) begin
				expPc = rxValue; // Absolute target
			end else if (take) begin
				expPc = expPc + 16'd4 + (want.imm << 2); // Word offset
			end else begin
				expPc = expPc + 16'd4;
			end
		end
	end

	// Stimulus on the falling edge
	initial begin
		rst        = 1'b1;
		stall      = 1'b0;
		rxValue    = 16'd0;
		tFlag      = 1'b0;
		expPc      = 16'd0;
		synced     = 1'b0;
		checkCount = 0;
		errorCount = 0;
		void'($urandom(54243));
		$readmemh("program.hex", progMem);
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst   = 1'b0;
		stall = 1'b1; // PC parked at 0
		repeat (4) @(negedge clk);
		stall   = 1'b0;
		rxValue = 16'h0001; // BEQZ falls through
		tFlag   = 1'b1;     // BTEQZ too
		repeat (SeqCycles) @(negedge clk);
		repeat (RandCycles) begin
			rst   = ($urandom % 30) == 0;
			stall = ($urandom % 6) == 0;
			tFlag = 1'($urandom % 2);
			if ($urandom % 3 == 0) begin
				rxValue = 16'd0; // Zero often
			end else begin
				rxValue = 16'(($urandom % (MemWords + 8)) * 4); // Some past the end
			end
			@(negedge clk);
		end
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#((TestCycles + 20) * 100);
		$display("Timeout: the run did not finish in %0d cycles", TestCycles + 20);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== program.hex ====
// One 16-bit instruction word per line in hex, word address 0 first
// Assembly of each word follows it
6801 // LI R0 0x01
69FF // LI R1 0xFF, zero-extended
5A80 // SLTUI R2 0x80, zero-extended
4BFF // ADDIU R3 -1
402E // ADDIU3 R0 R1 -2
3220 // SLL R2 R1 0, shifts by 8
332F // SRA R3 R1 3
E271 // ADDU R2 R3 R4
E417 // SUBU R4 R0 R5
E94C // AND R1 R2
EB8D // OR R3 R4
E82A // CMP R0 R1
EA6B // NEG R2 R3
ECAF // NOT R4 R5
EEE2 // SLT R6 R7
7FC0 // MOVE R7 R6
995F // LW R1 R2 -1
DB85 // SW R3 R4 5
9510 // LW_SP R5 0x10
D6F0 // SW_SP R6 -16
6381 // ADDSP -127
6440 // MTSP R2
F300 // MFIH R3
F401 // MTIH R4
ED40 // MFPC R5
2002 // BEQZ R0 +2
29FD // BNEZ R1 -3
6001 // BTEQZ +1
0000 // illegal opcode
0801 // illegal, not the nop word
3001 // illegal shift function
E81F // illegal ALU function
0800 // NOP
EB00 // JR R3
17DD // B -35, back to 0
2204 // BEQZ R2 +4, past the end
1064 // B +100, far past the end
60EC // BTEQZ -20
6441 // illegal MTSP low bits
17D8 // B -40, back to 0

// ==== filelist.f ====
src/mips16Pkg.sv
src/instrRom.sv
src/instrDecoder.sv
src/pcUnit.sv
src/mips16Fetch.sv
tb/mips16FetchTb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = mips16FetchTb
FILELIST = filelist.f
OBJDIR   = obj_dir
PASSMSG  = PASS: all tests

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)
